// ==== popeye_cen.sv ====
//////////////////////////////////////////////////
// Clock enables from the 20 MHz clock: pixel
// enable every 2nd clock, half rate every 4th
//////////////////////////////////////////////////

module popeye_cen (
    input  logic clk,        // 20 MHz
    input  logic arst_n,
    output logic pxl_cen,    // 10 MHz pixel enable
    output logic half_cen    // 5 MHz, lines up with every other pxl_cen
);

logic [1:0] cnt;    // Free running divider

always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
        cnt      <= 2'd0;
        pxl_cen  <= 1'b0;
        half_cen <= 1'b0;
    end else begin
        cnt      <= cnt + 2'd1;
        pxl_cen  <= ~cnt[0];        // High on the first clk after release
        half_cen <= cnt == 2'd0;    // Same phase, half as often
    end
end

endmodule

// ==== popeye_colmix.sv ====
//////////////////////////////////////////////////
// Colour mixer. Palette lookup of the text pixel,
// black during blanking. Last pipeline stage
//////////////////////////////////////////////////

module popeye_colmix
    import popeye_pkg::*;
(
    input  logic       clk,
    input  logic       arst_n,
    input  logic       pxl_cen,
    input  txt_pix_t   txt,
    input  prom_wr_t   prom_wr,
    output logic [2:0] red,
    output logic [2:0] green,
    output logic [2:0] blue,
    output logic       hb,
    output logic       vb
);

logic [7:0] pal_ram [0:PAL_SIZE-1];
logic [7:0] pal_byte;

always_ff @(posedge clk) begin
    if (prom_wr.region == REG_PAL) pal_ram[prom_wr.addr[4:0]] <= prom_wr.data;
end

// Only the lower 16 entries are reachable
assign pal_byte = pal_ram[{1'b0, txt.color, txt.pix}];

always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
        red   <= 3'd0;
        green <= 3'd0;
        blue  <= 3'd0;
        hb    <= 1'b0;
        vb    <= 1'b0;
    end else if (pxl_cen) begin
        hb <= txt.hb;
        vb <= txt.vb;
        if (txt.hb || txt.vb) begin
            red   <= 3'd0;                     // Blank to black
            green <= 3'd0;
            blue  <= 3'd0;
        end else begin
            red   <= pal_byte[7:5];
            green <= pal_byte[4:2];
            blue  <= {pal_byte[1:0], 1'b0};    // LSB is always zero
        end
    end
end

a_blank_black: assert property (@(posedge clk) disable iff (!arst_n)
    hb || vb |-> {red, green, blue} == 9'd0);

endmodule

// ==== popeye_game.sv ====
//////////////////////////////////////////////////
// Video subsystem top. Timing, text and colour
// stages in a row, plus the download decoder
//////////////////////////////////////////////////

module popeye_game
    import popeye_pkg::*;
(
    input  logic        clk,          // 20 MHz
    input  logic        arst_n,
    input  logic        cpu_we,
    input  logic [ 9:0] cpu_addr,
    input  logic [ 7:0] cpu_din,
    input  logic [11:0] ioctl_addr,
    input  logic [ 7:0] ioctl_data,
    input  logic        ioctl_wr,
    output logic        pxl_cen,      // 10 MHz pixel clock
    output logic [ 2:0] red,
    output logic [ 2:0] green,
    output logic [ 2:0] blue,         // LSB is always zero
    output logic        HB,           // horizontal blanking
    output logic        VB,           // vertical blanking
    output logic        HS,
    output logic        VS
);

logic     half_cen;
prom_wr_t prom_wr;     // Shared by char ROM and palette
raster_t  raster;
txt_pix_t txt;

assign HS = HB;
assign VS = VB;

popeye_cen u_cen (
    .clk        ( clk       ),
    .arst_n     ( arst_n    ),
    .pxl_cen    ( pxl_cen   ),
    .half_cen   ( half_cen  )
);

popeye_prom_we u_prom_we (
    .clk        ( clk        ),
    .arst_n     ( arst_n     ),
    .ioctl_addr ( ioctl_addr ),
    .ioctl_data ( ioctl_data ),
    .ioctl_wr   ( ioctl_wr   ),
    .prom_wr    ( prom_wr    )
);

popeye_timing u_timing (
    .clk        ( clk       ),
    .arst_n     ( arst_n    ),
    .pxl_cen    ( pxl_cen   ),
    .half_cen   ( half_cen  ),    // Line end strobe
    .raster     ( raster    )
);

popeye_txt u_txt (
    .clk        ( clk       ),
    .arst_n     ( arst_n    ),
    .pxl_cen    ( pxl_cen   ),
    .raster     ( raster    ),
    .cpu_we     ( cpu_we    ),
    .cpu_addr   ( cpu_addr  ),
    .cpu_din    ( cpu_din   ),
    .prom_wr    ( prom_wr   ),
    .txt        ( txt       )
);

popeye_colmix u_colmix (
    .clk        ( clk       ),
    .arst_n     ( arst_n    ),
    .pxl_cen    ( pxl_cen   ),
    .txt        ( txt       ),
    .prom_wr    ( prom_wr   ),
    .red        ( red       ),
    .green      ( green     ),
    .blue       ( blue      ),
    .hb         ( HB        ),    // Aligned with rgb
    .vb         ( VB        )
);

endmodule

// ==== popeye_pkg.sv ====
//////////////////////////////////////////////////
// Common definitions for the video subsystem:
// raster geometry, download map, pipeline types.
// Blocks pull it in with a wildcard import
//////////////////////////////////////////////////

package popeye_pkg;

    // Horizontal raster, counted in pixels
    localparam logic [8:0] H_VISIBLE = 9'd256;
    localparam logic [8:0] H_TOTAL   = 9'd320;   // 64 blanked pixels

    // Vertical raster, counted in lines
    localparam logic [8:0] V_VISIBLE = 9'd224;
    localparam logic [8:0] V_TOTAL   = 9'd264;   // 40 blanked lines

    // Text layer in 8x8 tiles
    localparam int TILE_COLS = 32;
    localparam int TILE_ROWS = 28;

    // Download map, byte addresses
    // 256 characters of 8 rows, MSB is the leftmost pixel
    localparam logic [11:0] CHAR_BASE = 12'h000;
    localparam logic [11:0] PAL_BASE  = 12'h800;
    localparam logic [11:0] PAL_SIZE  = 12'd32;  // R[7:5] G[4:2] B[1:0]

    // Pixel periods from counter value to rgb
    localparam int PIPE_DEPTH = 3;

    // Target of a download write
    typedef enum logic [1:0] {
        REG_CHAR = 2'd0,
        REG_PAL  = 2'd1,
        REG_NONE = 2'd2        // idle or out of range
    } prom_region_e;

    // Registered download write
    typedef struct packed {
        logic [10:0]  addr;    // offset inside the region
        logic [ 7:0]  data;
        prom_region_e region;
    } prom_wr_t;

    // Raster position out of the timing stage
    typedef struct packed {
        logic [8:0] h;
        logic [8:0] v;
        logic       hb;
        logic       vb;
    } raster_t;

    // Text pixel out of the tile stage
    typedef struct packed {
        logic       pix;
        logic [2:0] color;     // Top bits of the tile code
        logic       hb;
        logic       vb;
    } txt_pix_t;

endpackage

// ==== popeye_prom_we.sv ====
//////////////////////////////////////////////////
// Download decoder. Sorts each ioctl byte into
// character ROM or palette PROM and registers it
//////////////////////////////////////////////////

module popeye_prom_we
    import popeye_pkg::*;
(
    input  logic        clk,
    input  logic        arst_n,
    input  logic [11:0] ioctl_addr,
    input  logic [ 7:0] ioctl_data,
    input  logic        ioctl_wr,
    output prom_wr_t    prom_wr
);

logic [11:0]  char_off, pal_off;
logic [10:0]  addr_nxt, addr_q;
logic [ 7:0]  data_q;
prom_region_e region_nxt, region_q;

// Address classification
always_comb begin
    char_off = ioctl_addr - CHAR_BASE;
    pal_off  = ioctl_addr - PAL_BASE;
    if (ioctl_addr < PAL_BASE) begin
        region_nxt = REG_CHAR;
        addr_nxt   = char_off[10:0];
    end else if (ioctl_addr < PAL_BASE + PAL_SIZE) begin
        region_nxt = REG_PAL;
        addr_nxt   = pal_off[10:0];
    end else begin
        region_nxt = REG_NONE;        // Beyond palette, dropped
        addr_nxt   = pal_off[10:0];
    end
end

always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) region_q <= REG_NONE;
    else         region_q <= ioctl_wr ? region_nxt : REG_NONE;
end

always_ff @(posedge clk) begin
    if (ioctl_wr) begin
        addr_q <= addr_nxt;
        data_q <= ioctl_data;
    end
end

assign prom_wr = '{addr: addr_q, data: data_q, region: region_q};

// No write may reach a memory one clock after an idle strobe
a_idle_none: assert property (@(posedge clk) disable iff (!arst_n)
    !$past(ioctl_wr) |-> prom_wr.region == REG_NONE);

endmodule

// ==== popeye_timing.sv ====
//////////////////////////////////////////////////
// Raster counters and blanking flags, first
// pipeline stage. Steps once per pixel enable
//////////////////////////////////////////////////

module popeye_timing
    import popeye_pkg::*;
(
    input  logic    clk,
    input  logic    arst_n,
    input  logic    pxl_cen,
    input  logic    half_cen,
    output raster_t raster
);

logic [8:0] h, v;
logic [8:0] h_nxt, v_nxt;
logic       hb, vb;
logic       h_wrap;
logic       line_end;    // Armed on half_cen ahead of the wrap

assign h_wrap = h == H_TOTAL - 9'd1;

always_comb begin
    h_nxt = h_wrap ? 9'd0 : h + 9'd1;
    v_nxt = v;
    if (h_wrap && line_end) begin
        v_nxt = (v == V_TOTAL - 9'd1) ? 9'd0 : v + 9'd1;
    end
end

// half_cen only sees even h values, so 318 is caught
// and the strobe holds across the 319 -> 0 step
always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n)       line_end <= 1'b0;
    else if (half_cen) line_end <= h == H_TOTAL - 9'd2;
end

always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
        h  <= 9'd0;
        v  <= 9'd0;
        hb <= 1'b0;
        vb <= 1'b0;
    end else if (pxl_cen) begin
        h  <= h_nxt;
        v  <= v_nxt;
        hb <= h_nxt >= H_VISIBLE;    // Flags match the new count
        vb <= v_nxt >= V_VISIBLE;
    end
end

assign raster = '{h: h, v: v, hb: hb, vb: vb};

a_h_range: assert property (@(posedge clk) disable iff (!arst_n)
    h < H_TOTAL);

// The line strobe must be up whenever h wraps or v would stall
a_line_end: assert property (@(posedge clk) disable iff (!arst_n)
    pxl_cen && h_wrap |-> line_end);

endmodule

// ==== popeye_txt.sv ====
//////////////////////////////////////////////////
// Text layer: tile RAM then character ROM bit.
// Two pixel stages, blanking carried alongside
//////////////////////////////////////////////////

module popeye_txt
    import popeye_pkg::*;
(
    input  logic        clk,
    input  logic        arst_n,
    input  logic        pxl_cen,
    input  raster_t     raster,
    input  logic        cpu_we,
    input  logic [ 9:0] cpu_addr,
    input  logic [ 7:0] cpu_din,
    input  prom_wr_t    prom_wr,
    output txt_pix_t    txt
);

logic [7:0] tile_ram [0:1023];    // 32 columns per row
logic [7:0] char_rom [0:2047];    // {code, row} per byte

logic [9:0] tile_addr;
logic [7:0] char_row;

// Stage one
logic [7:0] s1_code;
logic [2:0] s1_hcol, s1_vrow;     // Position inside the tile
logic       s1_hb, s1_vb;

// Stage two
logic       pix_q;
logic [2:0] color_q;
logic       hb_q, vb_q;

// Row v/8, column h/8
assign tile_addr = 10'(raster.v[7:3] * TILE_COLS) + 10'(raster.h[7:3]);

// CPU port writes, raster port reads
always_ff @(posedge clk) begin
    if (cpu_we) tile_ram[cpu_addr] <= cpu_din;    // No enable needed
    if (pxl_cen) begin
        s1_code <= tile_ram[tile_addr];
        s1_hcol <= raster.h[2:0];
        s1_vrow <= raster.v[2:0];
    end
end

// Character ROM load and lookup
always_ff @(posedge clk) begin
    if (prom_wr.region == REG_CHAR) char_rom[prom_wr.addr] <= prom_wr.data;
end

assign char_row = char_rom[{s1_code, s1_vrow}];

always_ff @(posedge clk) begin
    if (pxl_cen) begin
        pix_q   <= char_row[~s1_hcol];    // MSB first
        color_q <= s1_code[7:5];
    end
end

// Blanking follows the data
always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
        s1_hb <= 1'b0;
        s1_vb <= 1'b0;
        hb_q  <= 1'b0;
        vb_q  <= 1'b0;
    end else if (pxl_cen) begin
        s1_hb <= raster.hb;
        s1_vb <= raster.vb;
        hb_q  <= s1_hb;
        vb_q  <= s1_vb;
    end
end

assign txt = '{pix: pix_q, color: color_q, hb: hb_q, vb: vb_q};

// Visible lines stay inside the tile map
a_tile_rows: assert property (@(posedge clk) disable iff (!arst_n)
    !raster.vb |-> int'(raster.v[8:3]) < TILE_ROWS);

endmodule

// ==== project.f ====
+incdir+.
popeye_pkg.sv
popeye_cen.sv
popeye_prom_we.sv
popeye_timing.sv
popeye_txt.sv
popeye_colmix.sv
popeye_game.sv
tb_popeye.sv

// ==== tb_popeye_tests.svh ====
//////////////////////////////////////////////////
// Directed tests of the video subsystem, included
// inside the testbench module
//////////////////////////////////////////////////

`ifndef TB_POPEYE_TESTS_SVH
`define TB_POPEYE_TESTS_SVH

// Checks one frame from VB fall to VB rise against the models
task automatic check_frame();
    logic [8:0] exp;
    int         visible;
    logic       done;
    visible = 0;
    done    = 1'b0;
    pixel_sample();
    while (!frame_start) pixel_sample();
    while (!done) begin
        if (HB || VB) begin
            exp = 9'd0;    // Blanked sample is black
        end else begin
            exp = expected_rgb(col, line);
            visible++;
        end
        if (red !== exp[8:6]) report_mismatch("red", red, exp[8:6]);
        if (green !== exp[5:3]) report_mismatch("green", green, exp[5:3]);
        if (blue !== exp[2:0]) report_mismatch("blue", blue, exp[2:0]);
        done = VB;
        if (!done) pixel_sample();
    end
    if (visible != H_VISIBLE * V_VISIBLE)
        report_mismatch("visible pixel count", visible, H_VISIBLE * V_VISIBLE);
endtask

task automatic download_models();
    for (int i = 0; i < 2048; i++) ioctl_write(CHAR_BASE + 12'(i), char_model[i]);
    for (int i = 0; i < PAL_SIZE; i++) ioctl_write(PAL_BASE + 12'(i), pal_model[i]);
endtask

task automatic load_tiles();
    for (int i = 0; i < 1024; i++) cpu_write(10'(i), tile_model[i]);
endtask

task automatic reset_values();
    test_errs = 0;
    arst_n    = 1'b0;
    repeat (5) @(negedge clk);
    if (pxl_cen !== 1'b0) report_mismatch("pxl_cen", pxl_cen, 0);
    if (red !== 3'd0) report_mismatch("red", red, 0);
    if (green !== 3'd0) report_mismatch("green", green, 0);
    if (blue !== 3'd0) report_mismatch("blue", blue, 0);
    if (HB !== 1'b0) report_mismatch("HB", HB, 0);
    if (VB !== 1'b0) report_mismatch("VB", VB, 0);
    arst_n = 1'b1;    // Released on a falling edge
    for (int k = 1; k <= 16; k++) begin
        @(negedge clk);
        if (pxl_cen !== 1'(k % 2)) report_mismatch("pxl_cen", pxl_cen, k % 2);
        if (HB !== 1'b0) report_mismatch("HB", HB, 0);    // Still in visible area
        if (VB !== 1'b0) report_mismatch("VB", VB, 0);
        if (k == 1 && red !== 3'd0) report_mismatch("red", red, 0);
    end
    report_test("reset values and pixel enable");
endtask

task automatic raster_timing();
    int   hb_high, period, hb_rises;
    logic hb_prev, vb_prev, rise;
    test_errs = 0;
    hb_prev   = 1'b1;
    @(negedge clk);
    while (!(HB && !hb_prev)) begin
        hb_prev = HB;
        @(negedge clk);
    end
    repeat (2) begin    // Two full lines, clock by clock
        hb_high = 0;
        period  = 0;
        rise    = 1'b0;
        while (!rise) begin
            if (HB) hb_high++;
            if (HS !== HB) report_mismatch("HS", HS, HB);
            period++;
            hb_prev = HB;
            @(negedge clk);
            rise = HB && !hb_prev;
        end
        if (hb_high != 2 * (H_TOTAL - H_VISIBLE))
            report_mismatch("HB high clocks", hb_high, 2 * (H_TOTAL - H_VISIBLE));
        if (period != 2 * H_TOTAL) report_mismatch("HB period clocks", period, 2 * H_TOTAL);
    end
    vb_prev = 1'b1;
    @(negedge clk);
    while (!(VB && !vb_prev)) begin
        if (VS !== VB) report_mismatch("VS", VS, VB);
        vb_prev = VB;
        @(negedge clk);
    end
    hb_rises = 0;
    hb_prev  = HB;
    while (VB) begin
        if (VS !== VB) report_mismatch("VS", VS, VB);
        if (HS !== HB) report_mismatch("HS", HS, HB);
        if (HB && !hb_prev) hb_rises++;    // One per blanked line
        hb_prev = HB;
        @(negedge clk);
    end
    if (hb_rises != V_TOTAL - V_VISIBLE)
        report_mismatch("VB lines", hb_rises, V_TOTAL - V_VISIBLE);
    report_test("raster timing");
endtask

task automatic download_fill();
    logic [7:0] code;
    test_errs = 0;
    code      = rand_byte();
    foreach (char_model[i]) char_model[i] = 8'(i) ^ 8'(i >> 8);
    for (int r = 0; r < 8; r++) char_model[int'(code) * 8 + r] = 8'hFF;    // All ones
    foreach (pal_model[i]) pal_model[i] = rand_byte();
    foreach (tile_model[i]) tile_model[i] = code;
    download_models();
    load_tiles();
    check_frame();
    report_test("download and fill");
endtask

task automatic pattern_placement();
    test_errs = 0;
    // Row pattern by parity of the whole ROM address
    foreach (char_model[i]) char_model[i] = (^i[10:0]) ? 8'h3C : 8'hA5;
    foreach (tile_model[i]) tile_model[i] = rand_byte();
    download_models();    // Falls in vertical blanking
    load_tiles();
    check_frame();
    report_test("pattern placement");
endtask

task automatic out_of_range_download();
    test_errs = 0;
    for (int a = 12'h820; a <= 12'h83F; a++) ioctl_write(12'(a), rand_byte());
    check_frame();    // Models unchanged
    report_test("out of range download");
endtask

task automatic cpu_tile_update();
    logic [9:0] addr;
    logic [7:0] code;
    test_errs = 0;
    addr      = 10'(13 * TILE_COLS + 17);
    code      = tile_model[addr] ^ 8'hE0;    // New colour and row parity
    if (VB !== 1'b1) report_problem("tile write was not in vertical blanking");
    cpu_write(addr, code);
    tile_model[addr] = code;
    check_frame();
    report_test("CPU tile update");
endtask

`endif

// ==== tb_popeye.sv ====
//////////////////////////////////////////////////
// Testbench for the video subsystem top. Clock,
// reset, DUT, watchdog, pixel sampler and models.
// Directed tests come from the included header
//////////////////////////////////////////////////

module tb_popeye
    import popeye_pkg::*;
;
timeunit 1ns;
timeprecision 1ps;

localparam int FRAME_CLKS = 2 * H_TOTAL * V_TOTAL;        // 168960
localparam int DL_CLKS    = 2 * (2048 + PAL_SIZE) + 40;   // One byte per 2 clocks
localparam int MAX_CYCLES = 8 * FRAME_CLKS + 4 * DL_CLKS; // About 6 frames used
localparam int MAX_PRINTS = 10;                           // Per test

logic        clk;
logic        arst_n;
logic        cpu_we;
logic [ 9:0] cpu_addr;
logic [ 7:0] cpu_din;
logic [11:0] ioctl_addr;
logic [ 7:0] ioctl_data;
logic        ioctl_wr;
logic        pxl_cen;
logic [ 2:0] red, green, blue;
logic        HB, VB, HS, VS;

// Reference contents of the DUT memories
logic [7:0] char_model [0:2047];
logic [7:0] pal_model  [0:31];
logic [7:0] tile_model [0:1023];

logic [31:0] lcg_state = 32'h9f0334e6;
int          cycle_cnt;
int          test_errs, pass_cnt, fail_cnt;
int          col, line;              // Raster position of the last sample
logic        prev_hb, prev_vb;
logic        frame_start;            // VB fell at the last sample

popeye_game i_popeye_game (
    .clk        ( clk        ),
    .arst_n     ( arst_n     ),
    .cpu_we     ( cpu_we     ),
    .cpu_addr   ( cpu_addr   ),
    .cpu_din    ( cpu_din    ),
    .ioctl_addr ( ioctl_addr ),
    .ioctl_data ( ioctl_data ),
    .ioctl_wr   ( ioctl_wr   ),
    .pxl_cen    ( pxl_cen    ),
    .red        ( red        ),
    .green      ( green      ),
    .blue       ( blue       ),
    .HB         ( HB         ),
    .VB         ( VB         ),
    .HS         ( HS         ),
    .VS         ( VS         )
);

initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;    // 20 ns period
end

// Watchdog
initial begin
    cycle_cnt = 0;
    while (cycle_cnt < MAX_CYCLES) begin
        @(posedge clk);
        cycle_cnt++;
    end
    $display("Timeout: run stopped after %0d clock cycles", cycle_cnt);
    $display("SOME TESTS FAILED");
    $finish;
end

function automatic logic [7:0] rand_byte();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state[31:24];    // High bits are the better ones
endfunction

// Pixel (n, m) from tile map, character rows and palette layout
function automatic logic [8:0] expected_rgb(input int n, input int m);
    logic [7:0] code;
    logic [7:0] row;
    logic [7:0] pal;
    logic       bit_on;
    code   = tile_model[(m / 8) * TILE_COLS + n / 8];
    row    = char_model[int'(code) * 8 + m % 8];
    bit_on = row[7 - n % 8];                 // MSB is leftmost
    pal    = pal_model[{code[7:5], bit_on}];
    return {pal[7:5], pal[4:2], pal[1:0], 1'b0};
endfunction

task automatic report_mismatch(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    test_errs++;
    if (test_errs <= MAX_PRINTS)
        $display("Fail at %0d ns: %s = %0h, expected %0h", $time, name, got, exp);
endtask

task automatic report_problem(input string what);
    test_errs++;
    $display("Error at %0d ns: %s", $time, what);
endtask

task automatic report_test(input string name);
    if (test_errs == 0) begin
        pass_cnt++;
        $display("PASS  %s", name);
    end else begin
        fail_cnt++;
        $display("FAIL  %s, %0d errors", name, test_errs);
    end
endtask

// Next falling edge with pxl_cen high, tracks column and line
task automatic pixel_sample();
    @(negedge clk);
    while (!pxl_cen) @(negedge clk);
    frame_start = prev_vb && !VB;
    if (prev_hb && !HB) begin
        col  = 0;
        line = frame_start ? 0 : line + 1;
    end else begin
        col++;
    end
    prev_hb = HB;
    prev_vb = VB;
endtask

task automatic cpu_write(input logic [9:0] addr, input logic [7:0] data);
    @(negedge clk);
    cpu_we   = 1'b1;
    cpu_addr = addr;
    cpu_din  = data;
    @(negedge clk);
    cpu_we   = 1'b0;    // One-clock strobe
endtask

task automatic ioctl_write(input logic [11:0] addr, input logic [7:0] data);
    @(negedge clk);
    ioctl_wr   = 1'b1;
    ioctl_addr = addr;
    ioctl_data = data;
    @(negedge clk);
    ioctl_wr   = 1'b0;
endtask

`include "tb_popeye_tests.svh"

initial begin
    arst_n     = 1'b0;
    cpu_we     = 1'b0;
    cpu_addr   = '0;
    cpu_din    = '0;
    ioctl_addr = '0;
    ioctl_data = '0;
    ioctl_wr   = 1'b0;
    pass_cnt   = 0;
    fail_cnt   = 0;
    col        = 0;
    line       = 0;
    prev_hb    = 1'b0;
    prev_vb    = 1'b0;
    reset_values();
    raster_timing();
    download_fill();
    pattern_placement();
    out_of_range_download();
    cpu_tile_update();
    $display("Tests passed: %0d, failed: %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0)
        $display("ALL TESTS PASSED");
    else
        $display("SOME TESTS FAILED");
    $finish;
end

endmodule
